// File: src/ifu_pkg.sv
package ifu_pkg;

  // ##########################################################################
  // widths and fixed values
  // ##########################################################################

  localparam int XLEN = 32;  // address and instruction width.

  // byte offset bits of a two-word cache line.
  localparam int LINE_OFF_W = 3;

  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;  // first fetch address.

  // fence.i with all operand fields zero.
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // ##########################################################################
  // RV32I major opcodes seen by the fetch stage
  // ##########################################################################

  typedef enum logic [6:0] {
    JAL      = 7'b110_1111,
    JALR     = 7'b110_0111,
    BRANCH   = 7'b110_0011,
    LOAD     = 7'b000_0011,
    STORE    = 7'b010_0011,
    SYSTEM   = 7'b111_0011,
    MISC_MEM = 7'b000_1111  // fence and fence.i.
  } opcode_e;

  // ##########################################################################
  // instruction cache refill states
  // ##########################################################################

  typedef enum logic [2:0] {
    IDLE   = 3'd0,  // lookup, a miss starts the refill.
    REQ_LO = 3'd1,  // waiting for the low word of the line.
    GAP    = 3'd2,  // request dropped for one cycle between beats.
    REQ_HI = 3'd3,  // waiting for the high word of the line.
    DONE   = 3'd4   // line is valid, lookups allowed again.
  } l1i_state_e;

endpackage

// File: src/l1i_if.sv
interface l1i_if;
  import ifu_pkg::*;

  logic [XLEN-1:0] pc;     // fetch address from the controller.
  logic            flush;  // one cycle pulse on an accepted fence.i.
  logic            hit;    // word at pc is present.
  logic [XLEN-1:0] inst;   // cached word at pc.
  logic            idle;   // no refill is running.

  modport ctrl (
    output pc,
    output flush,
    input  hit,
    input  inst,
    input  idle
  );

  modport cache (
    input  pc,
    input  flush,
    output hit,
    output inst,
    output idle
  );

endinterface

// File: src/l1i_cache.sv
module l1i_cache #(
  parameter int INDEX_W = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic [ifu_pkg::XLEN-1:0] bus_araddr_o,
  output logic                     bus_arvalid_o,
  output logic                     bus_busy_o,
  input  logic [ifu_pkg::XLEN-1:0] bus_rdata_i,
  input  logic                     bus_rvalid_i,
  l1i_if.cache                     port
);
  import ifu_pkg::*;

  localparam int SETS   = 2 ** INDEX_W;
  localparam int LINE_W = XLEN - LINE_OFF_W;  // line address bits.
  localparam int TAG_W  = LINE_W - INDEX_W;

  l1i_state_e state_q;

  logic [XLEN-1:0]  data_q [SETS][2];
  logic [TAG_W-1:0] tag_q  [SETS][2];
  logic [SETS-1:0]  valid_q;

  logic [LINE_W-1:0] miss_line_q;  // line being refilled.

  logic [TAG_W-1:0]   pc_tag;
  logic [INDEX_W-1:0] pc_idx;
  logic               pc_off;
  logic [LINE_W-1:0]  pc_line;
  logic [TAG_W-1:0]   fill_tag;
  logic [INDEX_W-1:0] fill_idx;
  logic               lookup;

  // ##########################################################################
  // lookup
  // ##########################################################################

  assign pc_line  = port.pc[XLEN-1:LINE_OFF_W];
  assign pc_tag   = pc_line[LINE_W-1:INDEX_W];
  assign pc_idx   = pc_line[INDEX_W-1:0];
  assign pc_off   = port.pc[2];
  assign fill_tag = miss_line_q[LINE_W-1:INDEX_W];
  assign fill_idx = miss_line_q[INDEX_W-1:0];

  // the tag store is only trusted while no refill is writing it.
  assign lookup = (state_q == IDLE) || (state_q == DONE);

  assign port.hit  = lookup && valid_q[pc_idx] && (tag_q[pc_idx][pc_off] == pc_tag);
  assign port.inst = data_q[pc_idx][pc_off];
  assign port.idle = (state_q == IDLE);

  // ##########################################################################
  // read bus
  // ##########################################################################

  always_comb begin
    case (state_q)
      IDLE:    bus_araddr_o = {pc_line, 3'b000};  // low word of the missing line.
      REQ_LO:  bus_araddr_o = {miss_line_q, 3'b000};
      default: bus_araddr_o = {miss_line_q, 3'b100};
    endcase
  end

  // no request in the gap cycle, so the second beat is a new request.
  assign bus_arvalid_o = ((state_q == IDLE) && !port.hit) ||
                         (state_q == REQ_LO) || (state_q == REQ_HI);
  assign bus_busy_o    = (state_q != IDLE);

  // ##########################################################################
  // refill state machine
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (port.flush) begin
            valid_q <= '0;  // fence.i drops every line.
          end
          if (bus_arvalid_o) begin
            state_q <= REQ_LO;
          end
        end
        REQ_LO: begin
          if (bus_rvalid_i) begin
            state_q <= GAP;
          end
        end
        GAP: begin
          state_q <= REQ_HI;
        end
        REQ_HI: begin
          if (bus_rvalid_i) begin
            state_q           <= DONE;
            valid_q[fill_idx] <= 1'b1;  // both words are in now.
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // line address is captured while idle and kept for the whole refill.
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      miss_line_q <= pc_line;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == REQ_LO) && bus_rvalid_i) begin
      data_q[fill_idx][0] <= bus_rdata_i;
      tag_q[fill_idx][0]  <= fill_tag;
    end
    if ((state_q == REQ_HI) && bus_rvalid_i) begin
      data_q[fill_idx][1] <= bus_rdata_i;
      tag_q[fill_idx][1]  <= fill_tag;
    end
  end

endmodule

// File: src/fetch_ctrl.sv
module fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  l1i_if.ctrl                      cache,
  input  logic                     next_ready_i,
  input  logic [ifu_pkg::XLEN-1:0] npc_i,
  input  logic [ifu_pkg::XLEN-1:0] res_pc_i,
  input  logic                     pc_change_i,
  input  logic                     pc_retire_i,
  input  logic                     load_retire_i,
  output logic [ifu_pkg::XLEN-1:0] pc_o,
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic                     valid_o,
  output logic                     spec_o,
  output logic                     bad_spec_o,
  output logic                     good_spec_o
);
  import ifu_pkg::*;

  opcode_e opcode;

  logic is_branch;
  logic is_jump;
  logic is_load;
  logic is_store;
  logic is_sys;
  logic is_fencei;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_seq;
  logic            lsu_hazard_q;  // waiting for a load to retire.
  logic            br_hazard_q;   // waiting for a branch or system outcome.

  logic [XLEN-1:0] btb_q;
  logic            btb_valid_q;
  logic            spec_q;
  logic            spec_cond_q;  // open speculation is a conditional branch.
  logic [XLEN-1:0] pred_q;
  logic [XLEN-1:0] fall_q;
  logic [XLEN-1:0] restart_q;
  logic            bad_q;
  logic            good_q;

  logic [XLEN-1:0] resolved_pc;
  logic            resolving;
  logic            good_now;
  logic            bad_now;
  logic            accept;
  logic            start_spec;

  // ##########################################################################
  // decode of the presented word
  // ##########################################################################

  assign opcode    = opcode_e'(cache.inst[6:0]);
  assign is_branch = (opcode == BRANCH);
  assign is_jump   = (opcode == JAL) || (opcode == JALR) || is_branch;
  assign is_load   = (opcode == LOAD);
  assign is_store  = (opcode == STORE);
  assign is_sys    = (opcode == SYSTEM);
  assign is_fencei = (opcode == MISC_MEM) && (cache.inst == INST_FENCE_I);

  // ##########################################################################
  // handshake toward the back end
  // ##########################################################################

  // fence.i waits for an idle cache so the flush pulse is not lost.
  assign valid_o = cache.hit && !lsu_hazard_q && !br_hazard_q && !bad_spec_o &&
                   !(spec_q && (is_load || is_store)) &&
                   !(is_fencei && !cache.idle);

  assign accept     = valid_o && next_ready_i;
  assign start_spec = accept && is_jump && btb_valid_q && !spec_q;
  assign pc_seq     = pc_q + XLEN'(4);

  assign pc_o        = pc_q;
  assign inst_o      = cache.inst;
  assign cache.pc    = pc_q;
  assign cache.flush = accept && is_fencei;

  // ##########################################################################
  // speculation outcome
  // ##########################################################################

  assign resolving   = spec_q && (pc_change_i || pc_retire_i);
  assign resolved_pc = pc_change_i ? npc_i : res_pc_i + XLEN'(4);
  assign good_now    = resolving && (resolved_pc == pred_q);
  assign bad_now     = resolving && (resolved_pc != pred_q);

  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q || bad_now;  // visible in the resolving cycle.

  // ##########################################################################
  // control state
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q         <= PC_INIT;
      lsu_hazard_q <= 1'b0;
      br_hazard_q  <= 1'b0;
      btb_valid_q  <= 1'b0;
      spec_q       <= 1'b0;
      spec_cond_q  <= 1'b0;
      bad_q        <= 1'b0;
      good_q       <= 1'b0;
    end else begin
      good_q <= good_now;  // one cycle pulse per good outcome.
      if (pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      if (resolving) begin
        spec_q <= 1'b0;
      end
      if (bad_now) begin
        bad_q <= 1'b1;
      end

      if (lsu_hazard_q && load_retire_i) begin
        lsu_hazard_q <= 1'b0;
        pc_q         <= pc_seq;
      end
      // an outcome while speculating belongs to the predicted branch.
      if (br_hazard_q && !spec_q && (pc_change_i || pc_retire_i)) begin
        br_hazard_q <= 1'b0;
        pc_q        <= pc_change_i ? npc_i : pc_seq;
      end

      if (accept) begin
        if (is_jump) begin
          if (start_spec) begin
            pc_q        <= btb_q;  // follow the last redirect target.
            spec_q      <= 1'b1;
            spec_cond_q <= is_branch;
          end else begin
            br_hazard_q <= 1'b1;
          end
        end else if (is_load) begin
          lsu_hazard_q <= 1'b1;
        end else if (is_sys) begin
          br_hazard_q <= 1'b1;
        end else begin
          pc_q <= pc_seq;
        end
      end

      // wrong path is dropped once the cache can take the new pc.
      if (bad_q && next_ready_i && cache.idle) begin
        bad_q        <= 1'b0;
        lsu_hazard_q <= 1'b0;
        br_hazard_q  <= 1'b0;
        spec_cond_q  <= 1'b0;
        pc_q         <= restart_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_change_i) begin
      btb_q <= npc_i;
    end
    if (start_spec) begin
      pred_q <= btb_q;
      fall_q <= pc_seq;
    end
    if (bad_now) begin
      restart_q <= (spec_cond_q && !pc_change_i) ? fall_q : npc_i;
    end
  end

endmodule

// File: src/ifu_top.sv
module ifu_top #(
  parameter int INDEX_W = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // read bus toward memory.
  output logic [ifu_pkg::XLEN-1:0] araddr_o,
  output logic                     arvalid_o,
  output logic                     busy_o,
  input  logic [ifu_pkg::XLEN-1:0] rdata_i,
  input  logic                     rvalid_i,

  // instruction stream toward the back end.
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic [ifu_pkg::XLEN-1:0] pc_o,
  output logic                     valid_o,
  input  logic                     next_ready_i,

  // branch and load resolution from the back end.
  input  logic [ifu_pkg::XLEN-1:0] npc_i,
  input  logic [ifu_pkg::XLEN-1:0] res_pc_i,
  input  logic                     pc_change_i,
  input  logic                     pc_retire_i,
  input  logic                     load_retire_i,

  output logic                     spec_o,
  output logic                     bad_spec_o,
  output logic                     good_spec_o
);

  l1i_if l1i_bus ();

  fetch_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cache         (l1i_bus.ctrl),
    .next_ready_i  (next_ready_i),
    .npc_i         (npc_i),
    .res_pc_i      (res_pc_i),
    .pc_change_i   (pc_change_i),
    .pc_retire_i   (pc_retire_i),
    .load_retire_i (load_retire_i),
    .pc_o          (pc_o),
    .inst_o        (inst_o),
    .valid_o       (valid_o),
    .spec_o        (spec_o),
    .bad_spec_o    (bad_spec_o),
    .good_spec_o   (good_spec_o)
  );

  l1i_cache #(
    .INDEX_W (INDEX_W)
  ) u_cache (
    .clk           (clk),
    .rst           (rst),
    .bus_araddr_o  (araddr_o),
    .bus_arvalid_o (arvalid_o),
    .bus_busy_o    (busy_o),
    .bus_rdata_i   (rdata_i),
    .bus_rvalid_i  (rvalid_i),
    .port          (l1i_bus.cache)
  );

endmodule

// File: sim/tb_ifu.sv
module tb_ifu;
  timeunit 1ns;
  timeprecision 100ps;
  import ifu_pkg::*;

  logic clk, rst, arvalid_o, busy_o, rvalid_i, valid_o, next_ready_i;
  logic pc_change_i, pc_retire_i, load_retire_i, spec_o, bad_spec_o, good_spec_o;
  logic [XLEN-1:0] araddr_o, rdata_i, inst_o, pc_o, npc_i, res_pc_i;
  logic [XLEN-1:0] gold [0:127];  // counts at 0, image pairs from 2, trace from 32.
  logic [XLEN-1:0] mem_addr, lo_addr, last_tgt;
  logic [26:0] line_tag [4];
  logic [26:0] snap_tag [4];
  logic [3:0] line_ok, snap_ok;
  logic spec_of [64];
  logic bad_of [64];
  int rq_due[$];
  int rq_idx[$];
  int ti, cyc, progress, last_prog, idle_cnt, err_val, err_other, mem_cnt, res_i;
  bit running, mem_busy, do_strobe, expect_hi, fence_seen, refetch_seen, load_wait;
  bit tgt_valid, spec_open, spec_check, good_check, exp_good, discard, seen_bad, res_active;

  ifu_top #(.INDEX_W(2)) DUT (
    .clk(clk), .rst(rst), .araddr_o(araddr_o), .arvalid_o(arvalid_o), .busy_o(busy_o),
    .rdata_i(rdata_i), .rvalid_i(rvalid_i), .inst_o(inst_o), .pc_o(pc_o), .valid_o(valid_o),
    .next_ready_i(next_ready_i), .npc_i(npc_i), .res_pc_i(res_pc_i),
    .pc_change_i(pc_change_i), .pc_retire_i(pc_retire_i), .load_retire_i(load_retire_i),
    .spec_o(spec_o), .bad_spec_o(bad_spec_o), .good_spec_o(good_spec_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // field 0 pc, 1 instruction, 2 resolution kind, 3 target.
  function automatic logic [XLEN-1:0] trace(input int i, input int f);
    return gold[32 + 4 * i + f];
  endfunction

  function automatic logic [XLEN-1:0] image_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] w;
    w = ~addr;  // unmapped words.
    for (int i = 0; i < int'(gold[0]); i++)
      if (gold[2 + 2 * i] == addr) w = gold[3 + 2 * i];
    return w;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_val++;
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic fail_note(input string msg);
    err_other++;
    $display("%0t %s", $time, msg);
  endtask

  // ##########################################################################
  // back end, accepted instructions and their resolution
  // ##########################################################################

  task automatic take_instruction();
    logic [6:0] op;
    assert (!load_wait) else fail_note("instruction accepted before the load retired");
    assert (!(inst_o[6:0] == STORE && spec_o)) else fail_note("store accepted while speculating");
    if (!discard && ti < int'(gold[1])) begin
      if (ti == 0) assert (pc_o == PC_INIT) else value_error("pc_o", pc_o, PC_INIT);
      assert (pc_o == trace(ti, 0)) else value_error("pc_o", pc_o, trace(ti, 0));
      assert (inst_o == trace(ti, 1)) else value_error("inst_o", inst_o, trace(ti, 1));
      assert (inst_o == image_word(trace(ti, 0)))
        else value_error("inst_o", inst_o, image_word(trace(ti, 0)));
      op = 7'(trace(ti, 1));
      spec_of[ti] = 1'b0;
      if ((op == JAL || op == JALR || op == BRANCH) && tgt_valid && !spec_open) begin
        spec_open   = 1'b1;
        spec_check  = 1'b1;
        spec_of[ti] = 1'b1;
        bad_of[ti]  = (ti + 1 < int'(gold[1])) && (trace(ti + 1, 0) != last_tgt);
        discard     = bad_of[ti];  // wrong path follows a bad guess.
        seen_bad    = 1'b0;
      end
      if (trace(ti, 2) != 0) begin
        rq_due.push_back(cyc + 1);
        rq_idx.push_back(ti);
      end
      if (trace(ti, 2) == 3) load_wait = 1'b1;
      if (trace(ti, 1) == INST_FENCE_I) begin
        snap_ok    = line_ok;
        snap_tag   = line_tag;
        line_ok    = '0;
        fence_seen = 1'b1;
      end
      ti++;
      progress++;
    end
  endtask

  task automatic finish_resolution();
    if (spec_of[res_i]) begin
      assert (bad_spec_o == bad_of[res_i])
        else value_error("bad_spec_o", bad_spec_o, bad_of[res_i]);
      exp_good   = !bad_of[res_i];
      good_check = 1'b1;
      spec_open  = 1'b0;
    end
    if (trace(res_i, 2) == 1) begin
      tgt_valid = 1'b1;
      last_tgt  = trace(res_i, 3);
    end
    if (trace(res_i, 2) == 3) load_wait = 1'b0;
    res_active = 1'b0;
    progress++;
  endtask

  task automatic check_request(input logic [XLEN-1:0] addr);
    if (!addr[2]) begin
      assert (addr[1:0] == 2'b00) else value_error("araddr_o", addr, {addr[31:3], 3'b000});
      assert (!expect_hi) else fail_note("new line requested before the second beat");
      assert (!(line_ok[addr[4:3]] && line_tag[addr[4:3]] == addr[31:5]))
        else fail_note("bus request for a line that is already valid");
      if (fence_seen && snap_ok[addr[4:3]] && snap_tag[addr[4:3]] == addr[31:5])
        refetch_seen = 1'b1;
      expect_hi = 1'b1;
      lo_addr   = addr;
    end else begin
      assert (expect_hi && addr == (lo_addr | 32'h4))
        else value_error("araddr_o", addr, lo_addr | 32'h4);
      expect_hi              = 1'b0;
      line_ok[addr[4:3]]  = 1'b1;
      line_tag[addr[4:3]] = addr[31:5];
    end
  endtask

  always @(posedge clk) begin
    if (running) begin
      cyc++;
      if (spec_check) begin
        assert (spec_o) else fail_note("spec_o stayed low after a buffered branch");
      end
      spec_check = 1'b0;
      if (good_check) begin
        assert (good_spec_o == exp_good)
          else value_error("good_spec_o", good_spec_o, exp_good);
      end
      good_check = 1'b0;
      if (discard && seen_bad && !bad_spec_o) discard = 1'b0;
      if (bad_spec_o) seen_bad = 1'b1;
      if (valid_o && next_ready_i) take_instruction();
      if (res_active) finish_resolution();
      do_strobe = 1'b0;
      if (rvalid_i) begin
        assert (busy_o) else fail_note("busy_o low while a refill word arrives");
        mem_busy = 1'b0;  // request is still up in the strobe cycle.
      end else if (mem_busy) begin
        mem_cnt--;
        do_strobe = (mem_cnt == 0);
      end else if (arvalid_o) begin
        check_request(araddr_o);
        mem_addr = araddr_o;
        mem_busy = 1'b1;
        mem_cnt  = 1 + int'($urandom % 4);
      end
      if (rq_due.size() > 0 && rq_due[0] == cyc) begin
        void'(rq_due.pop_front());
        res_i      = rq_idx.pop_front();
        res_active = 1'b1;
      end
      #2;
      next_ready_i  = ($urandom % 4) != 0;
      rvalid_i      = do_strobe;
      rdata_i       = image_word(mem_addr);
      pc_change_i   = res_active && trace(res_i, 2) == 1;
      pc_retire_i   = res_active && trace(res_i, 2) == 2;
      load_retire_i = res_active && trace(res_i, 2) == 3;
      npc_i         = trace(res_i, 3);
      res_pc_i      = trace(res_i, 0);
    end
  end

  // ##########################################################################
  // run control
  // ##########################################################################

  initial begin
    rst           = 1'b1;
    next_ready_i  = 1'b0;
    rvalid_i      = 1'b0;
    rdata_i       = '0;
    npc_i         = '0;
    res_pc_i      = '0;
    pc_change_i   = 1'b0;
    pc_retire_i   = 1'b0;
    load_retire_i = 1'b0;
    line_ok       = '0;
    void'($urandom(32'h3f3c_f734));
    $readmemh("sim/ifu_golden.txt", gold);
    repeat (10) @(posedge clk);
    #1;
    assert (!valid_o && !spec_o && !bad_spec_o && !good_spec_o && !busy_o)
      else fail_note("outputs are not idle during reset");
    #1;
    rst     = 1'b0;
    running = 1'b1;
    while (!(ti == int'(gold[1]) && rq_due.size() == 0 && !res_active && !spec_open &&
             !good_check && !load_wait) && idle_cnt < 200) begin
      @(posedge clk);
      #1;
      idle_cnt  = (progress != last_prog) ? 0 : idle_cnt + 1;
      last_prog = progress;
    end
    assert (idle_cnt < 200)
      else fail_note("timeout, the fetch trace made no progress for 200 cycles");
    assert (refetch_seen) else fail_note("no refill of an earlier line after fence.i");
    $display("errors: %0d value, %0d other, %0d of %0d trace entries", err_val, err_other,
             ti, int'(gold[1]));
    if (err_val + err_other == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sim/ifu_golden.txt
// word 0 image pair count, word 1 trace entry count, image from @02 as address word.
// trace from @20 as pc inst kind target, kind 0 none 1 taken 2 not taken 3 load.
@00
00000008 0000000f
@02
80000000 00200093
80000004 00000113
80000008 00002183
8000000c 00110113
80000010 00202023
80000014 fe111ce3
80000018 0000100f
8000001c fe0008e3
@20
80000000 00200093 00000000 00000000
80000004 00000113 00000000 00000000
80000008 00002183 00000003 00000000
8000000c 00110113 00000000 00000000
80000010 00202023 00000000 00000000
80000014 fe111ce3 00000001 8000000c
8000000c 00110113 00000000 00000000
80000010 00202023 00000000 00000000
80000014 fe111ce3 00000002 00000000
80000018 0000100f 00000000 00000000
8000001c fe0008e3 00000001 8000000c
8000000c 00110113 00000000 00000000
80000010 00202023 00000000 00000000
80000014 fe111ce3 00000001 8000000c
8000000c 00110113 00000000 00000000

// File: filelist.f
src/ifu_pkg.sv
src/l1i_if.sv
src/l1i_cache.sv
src/fetch_ctrl.sv
src/ifu_top.sv
sim/tb_ifu.sv

// File: Makefile
TOP := tb_ifu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o sim_ifu
	@out="$$(./obj_dir/sim_ifu)"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
